// ==== organ_top.f ====
+incdir+include
hw/organ_ctrl_pkg.sv
hw/organ_audio_pkg.sv
hw/key_repeat_ctrl.sv
hw/speed_reg.sv
hw/tone_gen.sv
hw/hex_display.sv
hw/organ_top.sv
dv/organ_chk.sv
dv/organ_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module organ_tb -f organ_top.f -o organ_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/organ_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Failure reported, see $LOG"
  exit 1
fi

echo "Simulation finished without a failure report"
exit 0

// ==== dv/organ_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module organ_tb;

  localparam int CLKS_PER_MS = 10;
  localparam int REFRESH_MS  = 5;
  localparam int INTERVAL    = `ORGAN_REPEAT_MS * CLKS_PER_MS;
  localparam int N_ACTIONS   = 40;
  // Directed holds: reset, down to min, reset, up to max, both keys, reset
  localparam int DIRECTED    = 1 + 125 + 1 + 485 + 2 + 1;
  localparam int CYCLE_LIMIT = (N_ACTIONS * 4 + DIRECTED + 1) * INTERVAL + 2000;
  localparam int SEED        = 32'h1f17_8a2f;
  localparam logic [23:0] DEF24 = 24'(`ORGAN_DEFAULT_PERIOD);

  // Common seven-segment font, active high, gfedcba
  localparam logic [6:0] FONT [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  // Pressed keys per action, bit 0 up, bit 1 down, bit 2 speed reset
  localparam logic [2:0] ACTION_KEYS [6] = '{
    3'b000, 3'b001, 3'b010, 3'b011, 3'b100, 3'b110
  };

  logic                     CLK_50M = 1'b0;
  logic                     rst_n;
  logic [2:0]               key;
  logic                     sample_req;
  organ_audio_pkg::sample_t sample_data;
  logic                     sample_ack;
  organ_ctrl_pkg::seg_t     hex [6];

  // Reference model
  int         model_offset = 0;
  logic [2:0] model_keys = 3'b000;
  int         cyc = 0;
  int         clk_count = 0;
  int         last_change = 0;

  int period_errs = 0;
  int seg_errs = 0;
  int sample_errs = 0;
  int other_errs = 0;

  // Sample monitor state
  organ_audio_pkg::sample_t exp_sample = `ORGAN_SAMPLE_HIGH;
  logic req_prev = 1'b0;
  int   rise_count = 0;
  int   prev_rise = 0;
  int   prev_period = 0;
  logic prev_stable = 1'b0;
  int   ack_delay;

  always #10 CLK_50M = ~CLK_50M;

  organ_top #(
    .CLKS_PER_MS (CLKS_PER_MS),
    .REFRESH_MS  (REFRESH_MS)
  ) uut (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key         (key),
    .sample_req  (sample_req),
    .sample_data (sample_data),
    .sample_ack  (sample_ack),
    .hex0        (hex[0]),
    .hex1        (hex[1]),
    .hex2        (hex[2]),
    .hex3        (hex[3]),
    .hex4        (hex[4]),
    .hex5        (hex[5])
  );

  // ==================================================
  // Compare tasks and display decoding
  // ==================================================

  task automatic check_period(input string name, input organ_ctrl_pkg::period_t exp,
                              input organ_ctrl_pkg::period_t act);
    if (act !== exp)
    begin
      period_errs++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_seg(input string name, input organ_ctrl_pkg::seg_t exp,
                           input organ_ctrl_pkg::seg_t act);
    if (act !== exp)
    begin
      seg_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_sample(input string name, input organ_audio_pkg::sample_t exp,
                              input organ_audio_pkg::sample_t act);
    if (act !== exp)
    begin
      sample_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic organ_ctrl_pkg::seg_t digit_seg(input logic [3:0] d);
    return ~FONT[d];
  endfunction

  // Bit 4 set when the pattern is a hex digit
  function automatic logic [4:0] seg_digit(input organ_ctrl_pkg::seg_t seg);
    logic [4:0] res;
    int         d;
    res = 5'h00;
    for (d = 0; d < 16; d++)
      if (digit_seg(4'(d)) == seg)
        res = {1'b1, 4'(d)};
    return res;
  endfunction

  task automatic read_period(output organ_ctrl_pkg::period_t value);
    logic [4:0] dig;
    int         i;
    value = '0;
    for (i = 3; i >= 0; i--)
    begin
      dig = seg_digit(hex[i]);
      if (!dig[4])
      begin
        other_errs++;
        $display("Display digit hex%0d shows a pattern that is no hex digit", i);
      end
      value = {value[11:0], dig[3:0]};
    end
    check_seg("hex4 upper digit", digit_seg(4'h0), hex[4]);
    check_seg("hex5 upper digit", digit_seg(4'h0), hex[5]);
  endtask

  // ==================================================
  // Model and stimulus
  // ==================================================

  function automatic organ_ctrl_pkg::period_t model_period();
    return organ_ctrl_pkg::period_t'(`ORGAN_DEFAULT_PERIOD + model_offset);
  endfunction

  task automatic try_step(input int delta);
    int p;
    p = `ORGAN_DEFAULT_PERIOD + model_offset + delta;
    if ((p >= `ORGAN_PERIOD_MIN) && (p <= `ORGAN_PERIOD_MAX))
    begin
      model_offset = model_offset + delta;
      last_change = clk_count;
    end
  endtask

  // Repeat boundary falls in the last cycle of each interval
  task automatic next_cycle();
    if ((cyc % INTERVAL == INTERVAL - 1) && !model_keys[2])
    begin
      if (model_keys[0] && !model_keys[1])
        try_step(`ORGAN_SPEED_STEP);
      else if (model_keys[1] && !model_keys[0])
        try_step(-`ORGAN_SPEED_STEP);
    end
    @(posedge CLK_50M);
    cyc++;
  endtask

  // Starts and ends in the middle of an interval
  task automatic hold_keys(input logic [2:0] pressed, input int intervals,
                           input string name, input int limit);
    organ_ctrl_pkg::period_t shown;
    int                      n;
    key <= ~pressed;
    model_keys = pressed;
    if (pressed[2] && (model_offset != 0))
    begin
      model_offset = 0;
      last_change = clk_count;
    end
    for (n = 0; n < intervals * INTERVAL - 1; n++)
      next_cycle();
    @(negedge CLK_50M);
    read_period(shown);
    check_period(name, model_period(), shown);
    if (limit >= 0)
      check_period({name, " limit"}, organ_ctrl_pkg::period_t'(limit), shown);
    next_cycle();
  endtask

  initial
  begin
    int n;
    int i;
    int action;
    organ_ctrl_pkg::period_t shown;
    void'($urandom(SEED));
    key        <= 3'b111;
    sample_ack <= 1'b0;
    rst_n      <= 1'b0;
    repeat (3) @(posedge CLK_50M);
    rst_n <= 1'b1;

    // Display right after reset
    for (n = 0; n < INTERVAL / 2 - 1; n++)
      next_cycle();
    @(negedge CLK_50M);
    for (i = 0; i < 6; i++)
      check_seg($sformatf("reset hex%0d", i), digit_seg(DEF24[4*i +: 4]), hex[i]);
    read_period(shown);
    check_period("reset period", organ_ctrl_pkg::period_t'(`ORGAN_DEFAULT_PERIOD), shown);
    next_cycle();

    for (n = 0; n < N_ACTIONS; n++)
    begin
      action = $urandom_range(5, 0);
      hold_keys(ACTION_KEYS[action], $urandom_range(4, 1), $sformatf("action %0d", n), -1);
    end

    // Walk to both clamp limits
    hold_keys(3'b100, 1, "speed reset", `ORGAN_DEFAULT_PERIOD);
    hold_keys(3'b010, 125, "down to lower limit", `ORGAN_PERIOD_MIN);
    hold_keys(3'b100, 1, "speed reset", `ORGAN_DEFAULT_PERIOD);
    hold_keys(3'b001, 485, "up to upper limit", `ORGAN_PERIOD_MAX);
    hold_keys(3'b011, 2, "up and down together", `ORGAN_PERIOD_MAX);
    hold_keys(3'b100, 1, "final speed reset", `ORGAN_DEFAULT_PERIOD);

    $display("Errors: period %0d, segment %0d, sample %0d, other %0d, assertion %0d",
             period_errs, seg_errs, sample_errs, other_errs, uut.u_chk.fail_count);
    if ((period_errs + seg_errs + sample_errs + other_errs == 0) &&
        (uut.u_chk.fail_count == 0))
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // ==================================================
  // Codec side and sample monitor
  // ==================================================

  initial
  begin
    forever
    begin
      @(negedge CLK_50M);
      if (sample_req && !sample_ack)
      begin
        ack_delay = $urandom_range(8, 1);
        repeat (ack_delay) @(posedge CLK_50M);
        sample_ack <= 1'b1;
        do
          @(negedge CLK_50M);
        while (sample_req);
        ack_delay = $urandom_range(8, 1);
        repeat (ack_delay) @(posedge CLK_50M);
        sample_ack <= 1'b0;
      end
    end
  end

  // Spacing only checked where the period held steady around the earlier edge
  always @(negedge CLK_50M)
  begin
    if (rst_n && sample_req && !req_prev)
    begin
      check_sample("delivered sample", exp_sample, sample_data);
      exp_sample = ~exp_sample;
      if ((rise_count > 0) && prev_stable)
        check_period("period from sample spacing", organ_ctrl_pkg::period_t'(prev_period),
                     organ_ctrl_pkg::period_t'(clk_count - prev_rise - 1));
      prev_stable = (clk_count - last_change > 8);
      prev_period = int'(model_period());
      prev_rise = clk_count;
      rise_count++;
    end
    req_prev = sample_req;
  end

  always @(posedge CLK_50M)
  begin
    clk_count <= clk_count + 1;
    if (clk_count >= CYCLE_LIMIT)
    begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/organ_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module organ_chk
(
  input logic                     CLK_50M,
  input logic                     rst_n,
  input logic                     sample_req,
  input organ_audio_pkg::sample_t sample_data,
  input logic                     sample_ack
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // ==================================================
  // Four-phase audio handshake
  // ==================================================

  req_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_req && !sample_ack |=> sample_req)
  else
  begin
    fail_count++;
    $error("sample_req dropped before sample_ack was seen");
  end

  data_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_req && $past(sample_req) |-> $stable(sample_data))
  else
  begin
    fail_count++;
    $error("sample_data changed while sample_req was high");
  end

  no_rise_on_ack: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    $rose(sample_req) |-> !sample_ack)
  else
  begin
    fail_count++;
    $error("sample_req rose while sample_ack was still high");
  end

  // Request still low on the first clocked cycle out of reset
  req_low_after_reset: assert property (@(posedge CLK_50M)
    $rose(rst_n) |=> !sample_req)
  else
  begin
    fail_count++;
    $error("sample_req high right after reset release");
  end

endmodule

bind organ_top organ_chk u_chk (
  .CLK_50M     (CLK_50M),
  .rst_n       (rst_n),
  .sample_req  (sample_req),
  .sample_data (sample_data),
  .sample_ack  (sample_ack)
);

`default_nettype wire

// ==== hw/organ_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module organ_top
#(
  parameter int CLKS_PER_MS = `ORGAN_CLKS_PER_MS,
  parameter int REFRESH_MS  = `ORGAN_REFRESH_MS
)
(
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  // Active low: 0 up, 1 down, 2 speed reset
  input  logic [2:0]               key,
  output logic                     sample_req,
  output organ_audio_pkg::sample_t sample_data,
  input  logic                     sample_ack,
  output organ_ctrl_pkg::seg_t     hex0,
  output organ_ctrl_pkg::seg_t     hex1,
  output organ_ctrl_pkg::seg_t     hex2,
  output organ_ctrl_pkg::seg_t     hex3,
  output organ_ctrl_pkg::seg_t     hex4,
  output organ_ctrl_pkg::seg_t     hex5
);

  organ_ctrl_pkg::speed_cmd_e cmd;
  organ_ctrl_pkg::period_t    period;

  // ==================================================
  // Speed control
  // ==================================================

  key_repeat_ctrl #(
    .CLKS_PER_MS (CLKS_PER_MS)
  ) u_key_repeat_ctrl (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .key     (key),
    .cmd     (cmd)
  );

  speed_reg u_speed_reg (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .period  (period)
  );

  // ==================================================
  // Tone output and display
  // ==================================================

  tone_gen u_tone_gen (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .period      (period),
    .sample_req  (sample_req),
    .sample_data (sample_data),
    .sample_ack  (sample_ack)
  );

  hex_display #(
    .CLKS_PER_MS (CLKS_PER_MS),
    .REFRESH_MS  (REFRESH_MS)
  ) u_hex_display (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .period  (period),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

`default_nettype wire

// ==== hw/hex_display.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module hex_display
#(
  parameter int CLKS_PER_MS = `ORGAN_CLKS_PER_MS,
  parameter int REFRESH_MS  = `ORGAN_REFRESH_MS
)
(
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  organ_ctrl_pkg::period_t period,
  output organ_ctrl_pkg::seg_t    hex0,
  output organ_ctrl_pkg::seg_t    hex1,
  output organ_ctrl_pkg::seg_t    hex2,
  output organ_ctrl_pkg::seg_t    hex3,
  output organ_ctrl_pkg::seg_t    hex4,
  output organ_ctrl_pkg::seg_t    hex5
);

  localparam int REFRESH_CLKS = REFRESH_MS * CLKS_PER_MS;
  localparam int RF_W         = $clog2(REFRESH_CLKS + 1);
  localparam logic [23:0] DEF_VAL = 24'(`ORGAN_DEFAULT_PERIOD);

  logic [RF_W-1:0]      rf_cnt;
  logic                 rf_hit;
  logic [23:0]          shown;
  organ_ctrl_pkg::seg_t seg_q [6];

  // Standard active-low hex patterns, g is the top bit
  function automatic organ_ctrl_pkg::seg_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  assign rf_hit = (rf_cnt == RF_W'(REFRESH_CLKS - 1));

  // Latch on refresh, decoded segments follow one cycle later
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rf_cnt <= '0;
      shown  <= DEF_VAL;
      for (int i = 0; i < 6; i++)
        seg_q[i] <= hex_to_seg(DEF_VAL[4*i +: 4]);
    end
    else
    begin
      rf_cnt <= rf_hit ? '0 : rf_cnt + RF_W'(1);
      if (rf_hit)
        shown <= {8'h00, period};
      for (int i = 0; i < 6; i++)
        seg_q[i] <= hex_to_seg(shown[4*i +: 4]);
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

`default_nettype wire

// ==== hw/tone_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module tone_gen
(
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  organ_ctrl_pkg::period_t  period,
  output logic                     sample_req,
  output organ_audio_pkg::sample_t sample_data,
  input  logic                     sample_ack
);

  localparam organ_ctrl_pkg::period_t DEF_PERIOD =
    organ_ctrl_pkg::period_t'(`ORGAN_DEFAULT_PERIOD);
  localparam organ_audio_pkg::sample_t SAMPLE_HIGH = `ORGAN_SAMPLE_HIGH;
  localparam organ_audio_pkg::sample_t SAMPLE_LOW  = `ORGAN_SAMPLE_LOW;

  organ_ctrl_pkg::period_t    div_cnt;
  organ_ctrl_pkg::period_t    period_q;
  logic                       level;
  logic                       toggle;
  organ_audio_pkg::sample_t   next_sample;
  logic                       pend_valid;
  organ_audio_pkg::sample_t   pend_data;
  logic                       launch;
  organ_audio_pkg::hs_state_e hs_state;

  // ==================================================
  // Tone divider
  // ==================================================

  assign toggle = (div_cnt == period_q);

  // Sample for the level after the toggle, high level maps to +127
  assign next_sample = level ? SAMPLE_LOW : SAMPLE_HIGH;

  // New period is picked up only at a toggle
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt  <= '0;
      period_q <= DEF_PERIOD;
      level    <= 1'b0;
    end
    else if (toggle)
    begin
      div_cnt  <= '0;
      period_q <= period;
      level    <= ~level;
    end
    else
      div_cnt <= div_cnt + organ_ctrl_pkg::period_t'(1);
  end

  // ==================================================
  // Pending sample and four-phase delivery
  // ==================================================

  assign launch = (hs_state == organ_audio_pkg::HS_IDLE) && pend_valid;

  // A toggle during a transfer overwrites the pending entry
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      pend_valid <= 1'b0;
    else if (toggle)
      pend_valid <= 1'b1;
    else if (launch)
      pend_valid <= 1'b0;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (toggle)
      pend_data <= next_sample;
    if (launch)
      sample_data <= pend_data;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      hs_state <= organ_audio_pkg::HS_IDLE;
    else
    begin
      case (hs_state)
        organ_audio_pkg::HS_IDLE:
          if (pend_valid)
            hs_state <= organ_audio_pkg::HS_REQ;
        organ_audio_pkg::HS_REQ:
          if (sample_ack)
            hs_state <= organ_audio_pkg::HS_RELEASE;
        organ_audio_pkg::HS_RELEASE:
          if (!sample_ack)
            hs_state <= organ_audio_pkg::HS_IDLE;
        default:
          hs_state <= organ_audio_pkg::HS_IDLE;
      endcase
    end
  end

  assign sample_req = (hs_state == organ_audio_pkg::HS_REQ);

endmodule

`default_nettype wire

// ==== hw/speed_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module speed_reg
(
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  organ_ctrl_pkg::speed_cmd_e  cmd,
  output organ_ctrl_pkg::period_t     period
);

  localparam organ_ctrl_pkg::period_t DEF_PERIOD =
    organ_ctrl_pkg::period_t'(`ORGAN_DEFAULT_PERIOD);
  localparam organ_ctrl_pkg::offset_t STEP = organ_ctrl_pkg::offset_t'(`ORGAN_SPEED_STEP);
  localparam organ_ctrl_pkg::period_t PERIOD_MIN = organ_ctrl_pkg::period_t'(`ORGAN_PERIOD_MIN);
  localparam organ_ctrl_pkg::period_t PERIOD_MAX = organ_ctrl_pkg::period_t'(`ORGAN_PERIOD_MAX);

  organ_ctrl_pkg::offset_t offset;
  organ_ctrl_pkg::offset_t try_offset;
  organ_ctrl_pkg::offset_t next_offset;
  organ_ctrl_pkg::period_t try_period;

  // Offset wraps modulo 2^16 above +32767, the 16-bit sum with the
  // default stays exact over the whole clamp range
  always_comb
  begin
    case (cmd)
      organ_ctrl_pkg::CMD_UP:    try_offset = offset + STEP;
      organ_ctrl_pkg::CMD_DOWN:  try_offset = offset - STEP;
      organ_ctrl_pkg::CMD_RESET: try_offset = '0;
      default:                   try_offset = offset;
    endcase
    try_period = DEF_PERIOD + organ_ctrl_pkg::period_t'(try_offset);
    if ((try_period >= PERIOD_MIN) && (try_period <= PERIOD_MAX))
      next_offset = try_offset;
    else
      next_offset = offset;
  end

  // Period registered alongside the offset, one cycle after cmd
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      offset <= '0;
      period <= DEF_PERIOD;
    end
    else
    begin
      offset <= next_offset;
      period <= DEF_PERIOD + organ_ctrl_pkg::period_t'(next_offset);
    end
  end

endmodule

`default_nettype wire

// ==== hw/key_repeat_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "organ_consts.svh"

module key_repeat_ctrl
#(
  parameter int CLKS_PER_MS = `ORGAN_CLKS_PER_MS
)
(
  input  logic                        CLK_50M,
  input  logic                        rst_n,
  input  logic [2:0]                  key,
  output organ_ctrl_pkg::speed_cmd_e  cmd
);

  localparam int MS_W  = $clog2(CLKS_PER_MS + 1);
  localparam int REP_W = $clog2(`ORGAN_REPEAT_MS + 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [2:0]       held;
  logic [MS_W-1:0]  ms_cnt;
  logic             ms_tick;
  logic [REP_W-1:0] rep_cnt;
  logic             rep_boundary;

  // ==================================================
  // Key synchronizers
  // ==================================================

  // Keys idle high, so the flops come out of reset released
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign held = ~key_sync;

  // ==================================================
  // Millisecond tick and repeat timer
  // ==================================================

  assign ms_tick      = (ms_cnt == MS_W'(CLKS_PER_MS - 1));
  assign rep_boundary = ms_tick && (rep_cnt == REP_W'(`ORGAN_REPEAT_MS - 1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ms_cnt  <= '0;
      rep_cnt <= '0;
    end
    else
    begin
      ms_cnt <= ms_tick ? '0 : ms_cnt + MS_W'(1);
      if (ms_tick)
        rep_cnt <= rep_boundary ? '0 : rep_cnt + REP_W'(1);
    end
  end

  // Speed reset wins; up and down only count at a boundary
  always_comb
  begin
    cmd = organ_ctrl_pkg::CMD_NONE;
    if (held[2])
      cmd = organ_ctrl_pkg::CMD_RESET;
    else if (rep_boundary && (held[0] ^ held[1]))
      cmd = held[0] ? organ_ctrl_pkg::CMD_UP : organ_ctrl_pkg::CMD_DOWN;
  end

endmodule

`default_nettype wire

// ==== hw/organ_audio_pkg.sv ====
`default_nettype none

package organ_audio_pkg;

  // Signed sample as sent to the codec
  typedef logic signed [7:0] sample_t;

  // Four-phase req/ack delivery states
  typedef enum logic [1:0]
  {
    HS_IDLE    = 2'd0,
    HS_REQ     = 2'd1,
    HS_RELEASE = 2'd2
  } hs_state_e;

endpackage

`default_nettype wire

// ==== hw/organ_ctrl_pkg.sv ====
`default_nettype none

package organ_ctrl_pkg;

  // ==================================================
  // Speed control
  // ==================================================

  // One-cycle commands from the key block to the offset register
  typedef enum logic [1:0]
  {
    CMD_NONE  = 2'd0,
    CMD_UP    = 2'd1,
    CMD_DOWN  = 2'd2,
    CMD_RESET = 2'd3
  } speed_cmd_e;

  // Tone divider count
  typedef logic [15:0] period_t;

  // Offset added to the default period
  typedef logic signed [15:0] offset_t;

  // ==================================================
  // Display
  // ==================================================

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

// ==== include/organ_consts.svh ====
`ifndef ORGAN_CONSTS_SVH
`define ORGAN_CONSTS_SVH

// ==================================================
// Tone period and speed control
// ==================================================

// Divider count at zero offset, about 2 kHz tone level rate
`define ORGAN_DEFAULT_PERIOD 12499

`define ORGAN_SPEED_STEP 100

// Allowed period range, inclusive
`define ORGAN_PERIOD_MIN 499
`define ORGAN_PERIOD_MAX 60499

// ==================================================
// Timing
// ==================================================

// Key repeat interval in ms
`define ORGAN_REPEAT_MS 100

`define ORGAN_CLKS_PER_MS 50000
`define ORGAN_REFRESH_MS 500

// ==================================================
// Audio sample levels
// ==================================================

`define ORGAN_SAMPLE_HIGH 8'h7F
`define ORGAN_SAMPLE_LOW 8'h80

`endif
